// ==== logic/mmu_pkg.sv ====
package mmu_pkg;

    // tlb geometry
    localparam int TLB_NUM   = 32;
    localparam int IDX_BITS  = 5;
    localparam int VPN2_BITS = 19;
    localparam int PFN_BITS  = 20;
    localparam int MASK_BITS = 12;
    localparam int ASID_BITS = 8;

    // same numbering as the MIPS exception codes
    localparam logic [1:0] FAULT_NONE = 2'd0;
    localparam logic [1:0] FAULT_MOD  = 2'd1;
    localparam logic [1:0] FAULT_TLBL = 2'd2;
    localparam logic [1:0] FAULT_TLBS = 2'd3;

    // maintenance commands
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_PROBE = 2'd2;

    typedef struct packed {
        logic [31:0] va;
        logic        store;
    } xlat_req_t;

    typedef struct packed {
        logic [31:0] pa;
        logic [2:0]  attr;
        logic [1:0]  fault;
        // miss only, not invalid or mod
        logic        refill;
    } xlat_rsp_t;

endpackage

// ==== logic/tlb_entry_array.sv ====
`timescale 1ns/1ps

module tlb_entry_array (
    input  logic clk,
    input  logic rst,
    input  logic maint_valid_i,
    input  logic [1:0] maint_op_i,
    input  logic [mmu_pkg::IDX_BITS-1:0] index_i,
    input  logic [31:0] entryhi_i,
    input  logic [31:0] entrylo0_i,
    input  logic [31:0] entrylo1_i,
    input  logic [mmu_pkg::MASK_BITS-1:0] mask_i,
    output logic [31:0] entryhi_o,
    output logic [31:0] entrylo0_o,
    output logic [31:0] entrylo1_o,
    output logic [mmu_pkg::MASK_BITS-1:0] mask_o,
    output logic [31:0] probe_index_o,
    output logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::VPN2_BITS-1:0] vpn2_o,
    output logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::ASID_BITS-1:0] asid_o,
    output logic [mmu_pkg::TLB_NUM-1:0] global_o,
    output logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::MASK_BITS-1:0] mask_tab_o,
    output logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::PFN_BITS-1:0] pfn0_o,
    output logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::PFN_BITS-1:0] pfn1_o,
    output logic [mmu_pkg::TLB_NUM-1:0][2:0] attr0_o,
    output logic [mmu_pkg::TLB_NUM-1:0][2:0] attr1_o,
    output logic [mmu_pkg::TLB_NUM-1:0] dirty0_o,
    output logic [mmu_pkg::TLB_NUM-1:0] dirty1_o,
    output logic [mmu_pkg::TLB_NUM-1:0] valid0_o,
    output logic [mmu_pkg::TLB_NUM-1:0] valid1_o
);

    logic wr_en;
    logic rd_en;
    logic pr_en;
    logic [mmu_pkg::VPN2_BITS-1:0] vmask_in;
    logic [mmu_pkg::PFN_BITS-1:0] pmask_in;
    logic [mmu_pkg::TLB_NUM-1:0] probe_hit;
    logic [mmu_pkg::IDX_BITS-1:0] probe_idx;

    assign wr_en = maint_valid_i && (maint_op_i == mmu_pkg::OP_WRITE);
    assign rd_en = maint_valid_i && (maint_op_i == mmu_pkg::OP_READ);
    assign pr_en = maint_valid_i && (maint_op_i == mmu_pkg::OP_PROBE);

    assign vmask_in = mmu_pkg::VPN2_BITS'(mask_i);
    assign pmask_in = mmu_pkg::PFN_BITS'(mask_i);

    // valid and global bits
    always_ff @(posedge clk) begin
        if (rst) begin
            global_o <= '0;
            valid0_o <= '0;
            valid1_o <= '0;
        end else if (wr_en) begin
            global_o[index_i] <= entrylo0_i[0] & entrylo1_i[0];
            valid0_o[index_i] <= entrylo0_i[1];
            valid1_o[index_i] <= entrylo1_i[1];
        end
    end

    // masked vpn2 and pfn bits are stored as zero
    always_ff @(posedge clk) begin
        if (wr_en) begin
            vpn2_o[index_i]     <= entryhi_i[31:13] & ~vmask_in;
            asid_o[index_i]     <= entryhi_i[mmu_pkg::ASID_BITS-1:0];
            mask_tab_o[index_i] <= mask_i;
            pfn0_o[index_i]     <= entrylo0_i[25:6] & ~pmask_in;
            pfn1_o[index_i]     <= entrylo1_i[25:6] & ~pmask_in;
            attr0_o[index_i]    <= entrylo0_i[5:3];
            attr1_o[index_i]    <= entrylo1_i[5:3];
            dirty0_o[index_i]   <= entrylo0_i[2];
            dirty1_o[index_i]   <= entrylo1_i[2];
        end
    end

    // associative probe against entryhi
    always_comb begin
        probe_idx = '0;
        for (int i = 0; i < mmu_pkg::TLB_NUM; i++) begin
            probe_hit[i] = ((entryhi_i[31:13] & ~mmu_pkg::VPN2_BITS'(mask_tab_o[i])) == vpn2_o[i])
                && (global_o[i] || (asid_o[i] == entryhi_i[mmu_pkg::ASID_BITS-1:0]));
            if (probe_hit[i]) begin
                probe_idx = probe_idx | mmu_pkg::IDX_BITS'(i);
            end
        end
    end

    // read back in cp0 layout
    always_ff @(posedge clk) begin
        if (rd_en) begin
            entryhi_o  <= {vpn2_o[index_i], 5'b0, asid_o[index_i]};
            entrylo0_o <= {6'b0, pfn0_o[index_i], attr0_o[index_i], dirty0_o[index_i],
                           valid0_o[index_i], global_o[index_i]};
            entrylo1_o <= {6'b0, pfn1_o[index_i], attr1_o[index_i], dirty1_o[index_i],
                           valid1_o[index_i], global_o[index_i]};
            mask_o     <= mask_tab_o[index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (pr_en) begin
            probe_index_o <= {~|probe_hit, (31 - mmu_pkg::IDX_BITS)'(0), probe_idx};
        end
    end

endmodule

// ==== logic/tlb_lookup.sv ====
`timescale 1ns/1ps

module tlb_lookup (
    input  logic [31:0] va_i,
    input  logic [mmu_pkg::ASID_BITS-1:0] asid_i,
    input  logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::VPN2_BITS-1:0] vpn2_i,
    input  logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::ASID_BITS-1:0] asid_tab_i,
    input  logic [mmu_pkg::TLB_NUM-1:0] global_i,
    input  logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::MASK_BITS-1:0] mask_tab_i,
    input  logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::PFN_BITS-1:0] pfn0_i,
    input  logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::PFN_BITS-1:0] pfn1_i,
    input  logic [mmu_pkg::TLB_NUM-1:0][2:0] attr0_i,
    input  logic [mmu_pkg::TLB_NUM-1:0][2:0] attr1_i,
    input  logic [mmu_pkg::TLB_NUM-1:0] dirty0_i,
    input  logic [mmu_pkg::TLB_NUM-1:0] dirty1_i,
    input  logic [mmu_pkg::TLB_NUM-1:0] valid0_i,
    input  logic [mmu_pkg::TLB_NUM-1:0] valid1_i,
    output logic hit_o,
    output logic [31:0] pa_o,
    output logic [2:0] attr_o,
    output logic valid_o,
    output logic dirty_o
);

    logic [mmu_pkg::TLB_NUM-1:0] match;

    always_comb begin
        logic [mmu_pkg::MASK_BITS-1:0] m;
        logic [mmu_pkg::MASK_BITS:0] sel_bit;
        logic odd;
        logic [mmu_pkg::PFN_BITS-1:0] pfn;
        logic [31:0] ent_pa;

        pa_o    = '0;
        attr_o  = '0;
        valid_o = 1'b0;
        dirty_o = 1'b0;
        for (int i = 0; i < mmu_pkg::TLB_NUM; i++) begin
            m = mask_tab_i[i];
            match[i] = ((va_i[31:13] & ~mmu_pkg::VPN2_BITS'(m)) == vpn2_i[i])
                && (global_i[i] || (asid_tab_i[i] == asid_i));

            // one-hot bit right above the mask run picks the odd page
            sel_bit = {m, 1'b1} & ~{1'b0, m};
            odd = |(va_i[24:12] & sel_bit);

            pfn = odd ? pfn1_i[i] : pfn0_i[i];
            ent_pa = {pfn, 12'b0} | (va_i & 32'({m, 12'hfff}));

            if (match[i]) begin
                pa_o    = pa_o | ent_pa;
                attr_o  = attr_o | (odd ? attr1_i[i] : attr0_i[i]);
                valid_o = valid_o | (odd ? valid1_i[i] : valid0_i[i]);
                dirty_o = dirty_o | (odd ? dirty1_i[i] : dirty0_i[i]);
            end
        end
    end

    assign hit_o = |match;

endmodule

// ==== logic/xlat_fault.sv ====
`timescale 1ns/1ps

module xlat_fault (
    input  logic store_i,
    input  logic hit_i,
    input  logic valid_i,
    input  logic dirty_i,
    input  logic [31:0] pa_i,
    input  logic [2:0] attr_i,
    output mmu_pkg::xlat_rsp_t rsp_o
);

    logic [1:0] miss_code;

    // load and store report different tlb codes
    assign miss_code = store_i ? mmu_pkg::FAULT_TLBS : mmu_pkg::FAULT_TLBL;

    always_comb begin
        rsp_o.pa     = pa_i;
        rsp_o.attr   = attr_i;
        rsp_o.fault  = mmu_pkg::FAULT_NONE;
        rsp_o.refill = 1'b0;
        if (!hit_i) begin
            rsp_o.fault  = miss_code;
            rsp_o.refill = 1'b1;
        end else if (!valid_i) begin
            rsp_o.fault = miss_code;
        end else if (store_i && !dirty_i) begin
            // write to clean page
            rsp_o.fault = mmu_pkg::FAULT_MOD;
        end
    end

endmodule

// ==== logic/xlat_pipe_stage.sv ====
`timescale 1ns/1ps

module xlat_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid_i,
    input  payload_t in_data_i,
    input  logic out_ready_i,
    output logic in_ready_o,
    output logic out_valid_o,
    output payload_t out_data_o
);

    // slot frees up when empty or draining this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready_o && in_valid_i) begin
            out_data_o <= in_data_i;
        end
    end

endmodule

// ==== logic/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top (
    input  logic clk,
    input  logic rst,
    input  logic req_valid_i,
    input  logic [31:0] req_va_i,
    input  logic req_store_i,
    output logic req_ready_o,
    output logic rsp_valid_o,
    output logic [31:0] rsp_pa_o,
    output logic [2:0] rsp_attr_o,
    output logic [1:0] rsp_fault_o,
    output logic rsp_refill_o,
    input  logic rsp_ready_i,
    input  logic [mmu_pkg::ASID_BITS-1:0] asid_i,
    input  logic maint_valid_i,
    input  logic [1:0] maint_op_i,
    input  logic [mmu_pkg::IDX_BITS-1:0] index_i,
    input  logic [31:0] entryhi_i,
    input  logic [31:0] entrylo0_i,
    input  logic [31:0] entrylo1_i,
    input  logic [mmu_pkg::MASK_BITS-1:0] mask_i,
    output logic [31:0] entryhi_o,
    output logic [31:0] entrylo0_o,
    output logic [31:0] entrylo1_o,
    output logic [mmu_pkg::MASK_BITS-1:0] mask_o,
    output logic [31:0] probe_index_o
);

    logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::VPN2_BITS-1:0] vpn2;
    logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::ASID_BITS-1:0] asid_tab;
    logic [mmu_pkg::TLB_NUM-1:0] global_tab;
    logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::MASK_BITS-1:0] mask_tab;
    logic [mmu_pkg::TLB_NUM-1:0][mmu_pkg::PFN_BITS-1:0] pfn0, pfn1;
    logic [mmu_pkg::TLB_NUM-1:0][2:0] attr0, attr1;
    logic [mmu_pkg::TLB_NUM-1:0] dirty0, dirty1, valid0, valid1;

    mmu_pkg::xlat_req_t req_word, req_q;
    mmu_pkg::xlat_rsp_t rsp_word, rsp_q;
    logic req_q_valid, rsp_in_ready;
    logic lk_hit, lk_valid, lk_dirty;
    logic [31:0] lk_pa;
    logic [2:0] lk_attr;

    assign req_word = {req_va_i, req_store_i};

    tlb_entry_array u_array (
        .clk, .rst, .maint_valid_i, .maint_op_i, .index_i,
        .entryhi_i, .entrylo0_i, .entrylo1_i, .mask_i,
        .entryhi_o, .entrylo0_o, .entrylo1_o, .mask_o, .probe_index_o,
        .vpn2_o(vpn2), .asid_o(asid_tab), .global_o(global_tab), .mask_tab_o(mask_tab),
        .pfn0_o(pfn0), .pfn1_o(pfn1), .attr0_o(attr0), .attr1_o(attr1),
        .dirty0_o(dirty0), .dirty1_o(dirty1), .valid0_o(valid0), .valid1_o(valid1)
    );

    xlat_pipe_stage #(.payload_t(mmu_pkg::xlat_req_t)) s_req (
        .clk, .rst, .in_valid_i(req_valid_i), .in_data_i(req_word),
        .out_ready_i(rsp_in_ready), .in_ready_o(req_ready_o),
        .out_valid_o(req_q_valid), .out_data_o(req_q)
    );

    tlb_lookup u_lookup (
        .va_i(req_q.va), .asid_i,
        .vpn2_i(vpn2), .asid_tab_i(asid_tab), .global_i(global_tab), .mask_tab_i(mask_tab),
        .pfn0_i(pfn0), .pfn1_i(pfn1), .attr0_i(attr0), .attr1_i(attr1),
        .dirty0_i(dirty0), .dirty1_i(dirty1), .valid0_i(valid0), .valid1_i(valid1),
        .hit_o(lk_hit), .pa_o(lk_pa), .attr_o(lk_attr), .valid_o(lk_valid), .dirty_o(lk_dirty)
    );

    xlat_fault u_fault (
        .store_i(req_q.store), .hit_i(lk_hit), .valid_i(lk_valid), .dirty_i(lk_dirty),
        .pa_i(lk_pa), .attr_i(lk_attr), .rsp_o(rsp_word)
    );

    xlat_pipe_stage #(.payload_t(mmu_pkg::xlat_rsp_t)) s_rsp (
        .clk, .rst, .in_valid_i(req_q_valid), .in_data_i(rsp_word),
        .out_ready_i(rsp_ready_i), .in_ready_o(rsp_in_ready),
        .out_valid_o(rsp_valid_o), .out_data_o(rsp_q)
    );

    assign rsp_pa_o     = rsp_q.pa;
    assign rsp_attr_o   = rsp_q.attr;
    assign rsp_fault_o  = rsp_q.fault;
    assign rsp_refill_o = rsp_q.refill;

endmodule

// ==== verification/mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb;

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic req_valid;
    logic [31:0] req_va;
    logic req_store;
    logic req_ready;
    logic rsp_valid;
    logic [31:0] rsp_pa;
    logic [2:0] rsp_attr;
    logic [1:0] rsp_fault;
    logic rsp_refill;
    logic rsp_ready;
    logic [mmu_pkg::ASID_BITS-1:0] asid;
    logic maint_valid;
    logic [1:0] maint_op;
    logic [mmu_pkg::IDX_BITS-1:0] index;
    logic [31:0] entryhi;
    logic [31:0] entrylo0;
    logic [31:0] entrylo1;
    logic [mmu_pkg::MASK_BITS-1:0] mask;
    logic [31:0] entryhi_rd;
    logic [31:0] entrylo0_rd;
    logic [31:0] entrylo1_rd;
    logic [mmu_pkg::MASK_BITS-1:0] mask_rd;
    logic [31:0] probe_index;

    // reference copy of the tlb
    logic [mmu_pkg::VPN2_BITS-1:0] m_vpn2 [0:mmu_pkg::TLB_NUM-1];
    logic [mmu_pkg::ASID_BITS-1:0] m_asid [0:mmu_pkg::TLB_NUM-1];
    logic [mmu_pkg::MASK_BITS-1:0] m_mask [0:mmu_pkg::TLB_NUM-1];
    logic [mmu_pkg::PFN_BITS-1:0] m_pfn0 [0:mmu_pkg::TLB_NUM-1];
    logic [mmu_pkg::PFN_BITS-1:0] m_pfn1 [0:mmu_pkg::TLB_NUM-1];
    logic [2:0] m_attr0 [0:mmu_pkg::TLB_NUM-1];
    logic [2:0] m_attr1 [0:mmu_pkg::TLB_NUM-1];
    logic m_glob [0:mmu_pkg::TLB_NUM-1];
    logic m_dirty0 [0:mmu_pkg::TLB_NUM-1];
    logic m_dirty1 [0:mmu_pkg::TLB_NUM-1];
    logic m_valid0 [0:mmu_pkg::TLB_NUM-1];
    logic m_valid1 [0:mmu_pkg::TLB_NUM-1];

    // requests waiting to be sent and the responses they should produce
    logic [31:0] send_va_q [$];
    logic send_st_q [$];
    logic [31:0] exp_pa_q [$];
    logic [2:0] exp_attr_q [$];
    logic [1:0] exp_fault_q [$];
    logic exp_refill_q [$];
    int accept_cycle_q [$];

    int value_errors;
    int timeouts;
    logic [31:0] rng_state;

    mmu_top dut0 (
        .clk(clk),
        .rst(rst),
        .req_valid_i(req_valid),
        .req_va_i(req_va),
        .req_store_i(req_store),
        .req_ready_o(req_ready),
        .rsp_valid_o(rsp_valid),
        .rsp_pa_o(rsp_pa),
        .rsp_attr_o(rsp_attr),
        .rsp_fault_o(rsp_fault),
        .rsp_refill_o(rsp_refill),
        .rsp_ready_i(rsp_ready),
        .asid_i(asid),
        .maint_valid_i(maint_valid),
        .maint_op_i(maint_op),
        .index_i(index),
        .entryhi_i(entryhi),
        .entrylo0_i(entrylo0),
        .entrylo1_i(entrylo1),
        .mask_i(mask),
        .entryhi_o(entryhi_rd),
        .entrylo0_o(entrylo0_rd),
        .entrylo1_o(entrylo1_rd),
        .mask_o(mask_rd),
        .probe_index_o(probe_index)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_fault(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_attr(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] attr,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, attr, d, v, g};
    endfunction

    // page offset width for a contiguous page mask
    function automatic int offset_bits(input logic [11:0] pm);
        int n;
        n = 12;
        for (int j = 0; j < 12; j++) begin
            if (pm[j]) n = 13 + j;
        end
        return n;
    endfunction

    function automatic logic entry_match(input int i, input logic [31:0] va,
                                         input logic [7:0] id);
        return ((va[31:13] & ~{7'b0, m_mask[i]}) == m_vpn2[i]) && (m_glob[i] || m_asid[i] == id);
    endfunction

    function automatic logic [31:0] model_probe(input logic [31:0] eh);
        logic [31:0] res;
        res = 32'h8000_0000;
        for (int i = 0; i < mmu_pkg::TLB_NUM; i++) begin
            if (entry_match(i, eh, eh[7:0])) res = i;
        end
        return res;
    endfunction

    task automatic model_write(input int idx, input logic [31:0] eh, input logic [31:0] lo0,
                               input logic [31:0] lo1, input logic [11:0] pm);
        m_vpn2[idx] = eh[31:13] & ~{7'b0, pm};
        m_asid[idx] = eh[7:0];
        m_mask[idx] = pm;
        m_glob[idx] = lo0[0] & lo1[0];
        m_pfn0[idx] = lo0[25:6] & ~{8'b0, pm};
        m_pfn1[idx] = lo1[25:6] & ~{8'b0, pm};
        m_attr0[idx] = lo0[5:3];
        m_attr1[idx] = lo1[5:3];
        m_dirty0[idx] = lo0[2];
        m_dirty1[idx] = lo1[2];
        m_valid0[idx] = lo0[1];
        m_valid1[idx] = lo1[1];
    endtask

    // queues one request with the response the model predicts for it
    task automatic queue_req(input logic [31:0] va, input logic st);
        int ob;
        logic hit;
        logic odd;
        logic v;
        logic d;
        logic [31:0] off;
        logic [31:0] pa;
        logic [2:0] attr;
        logic [1:0] miss_code;
        hit = 1'b0;
        v = 1'b0;
        d = 1'b0;
        pa = '0;
        attr = '0;
        for (int i = 0; i < mmu_pkg::TLB_NUM; i++) begin
            if (!hit && entry_match(i, va, asid)) begin
                hit = 1'b1;
                ob = offset_bits(m_mask[i]);
                odd = va[ob];
                off = (32'd1 << ob) - 32'd1;
                pa = {(odd ? m_pfn1[i] : m_pfn0[i]), 12'b0} | (va & off);
                attr = odd ? m_attr1[i] : m_attr0[i];
                v = odd ? m_valid1[i] : m_valid0[i];
                d = odd ? m_dirty1[i] : m_dirty0[i];
            end
        end
        miss_code = st ? mmu_pkg::FAULT_TLBS : mmu_pkg::FAULT_TLBL;
        send_va_q.push_back(va);
        send_st_q.push_back(st);
        exp_pa_q.push_back(pa);
        exp_attr_q.push_back(attr);
        exp_refill_q.push_back(!hit);
        if (!hit || !v) begin
            exp_fault_q.push_back(miss_code);
        end else if (st && !d) begin
            exp_fault_q.push_back(mmu_pkg::FAULT_MOD);
        end else begin
            exp_fault_q.push_back(mmu_pkg::FAULT_NONE);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic tlb_write(input int idx, input logic [31:0] eh, input logic [31:0] lo0,
                             input logic [31:0] lo1, input logic [11:0] pm);
        maint_valid = 1'b1;
        maint_op = mmu_pkg::OP_WRITE;
        index = mmu_pkg::IDX_BITS'(idx);
        entryhi = eh;
        entrylo0 = lo0;
        entrylo1 = lo1;
        mask = pm;
        next_cycle();
        maint_valid = 1'b0;
        model_write(idx, eh, lo0, lo1, pm);
    endtask

    task automatic tlb_read(input int idx);
        maint_valid = 1'b1;
        maint_op = mmu_pkg::OP_READ;
        index = mmu_pkg::IDX_BITS'(idx);
        next_cycle();
        maint_valid = 1'b0;
        @(negedge clk);
        check_word("entryhi_o", {m_vpn2[idx], 5'b0, m_asid[idx]}, entryhi_rd);
        check_word("entrylo0_o", make_lo(m_pfn0[idx], m_attr0[idx], m_dirty0[idx],
                   m_valid0[idx], m_glob[idx]), entrylo0_rd);
        check_word("entrylo1_o", make_lo(m_pfn1[idx], m_attr1[idx], m_dirty1[idx],
                   m_valid1[idx], m_glob[idx]), entrylo1_rd);
        check_word("mask_o", 32'(m_mask[idx]), 32'(mask_rd));
        next_cycle();
    endtask

    task automatic tlb_probe(input logic [31:0] eh);
        maint_valid = 1'b1;
        maint_op = mmu_pkg::OP_PROBE;
        entryhi = eh;
        next_cycle();
        maint_valid = 1'b0;
        @(negedge clk);
        check_word("probe_index_o", model_probe(eh), probe_index);
        next_cycle();
    endtask

    // sends the queued requests and checks every response in order
    task automatic run_stream(input bit check_lat, input bit backpressure, output int stalls);
        int cycle;
        int idle;
        int got;
        int total;
        int lat;
        logic [15:0] ready_pattern;
        ready_pattern = 16'b1100_0011_1000_1101;
        cycle = 0;
        idle = 0;
        got = 0;
        stalls = 0;
        total = exp_pa_q.size();
        while (got < total && idle < TIMEOUT) begin
            req_valid = send_va_q.size() > 0;
            if (send_va_q.size() > 0) begin
                req_va = send_va_q[0];
                req_store = send_st_q[0];
            end
            rsp_ready = backpressure ? ready_pattern[cycle % 16] : 1'b1;
            @(negedge clk);
            idle++;
            if (req_valid && !req_ready) stalls++;
            if (req_valid && req_ready) begin
                void'(send_va_q.pop_front());
                void'(send_st_q.pop_front());
                accept_cycle_q.push_back(cycle);
                idle = 0;
            end
            if (rsp_valid && rsp_ready) begin
                check_fault("rsp_fault_o", exp_fault_q.pop_front(), rsp_fault);
                check_flag("rsp_refill_o", exp_refill_q[0], rsp_refill);
                // nothing matched on a refill, so pa and attr carry no meaning
                if (!exp_refill_q.pop_front()) begin
                    check_word("rsp_pa_o", exp_pa_q[0], rsp_pa);
                    check_attr("rsp_attr_o", exp_attr_q[0], rsp_attr);
                end
                void'(exp_pa_q.pop_front());
                void'(exp_attr_q.pop_front());
                lat = cycle - accept_cycle_q.pop_front();
                if (check_lat && lat != 2) begin
                    value_errors++;
                    $display("Error at %0t: response latency expected 2 got %0d", $time, lat);
                end
                got++;
                idle = 0;
            end
            if (accept_cycle_q.size() > 2) begin
                value_errors++;
                $display("More than two requests in flight at %0t", $time);
            end
            cycle++;
            next_cycle();
        end
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        if (got < total) begin
            timeouts++;
            $display("Timeout: only %0d of %0d responses arrived", got, total);
            send_va_q.delete();
            send_st_q.delete();
            exp_pa_q.delete();
            exp_attr_q.delete();
            exp_fault_q.delete();
            exp_refill_q.delete();
            accept_cycle_q.delete();
        end else begin
            @(negedge clk);
            check_flag("rsp_valid_o", 1'b0, rsp_valid);
            next_cycle();
        end
    endtask

    // distinct vpn2 per entry, foreign asid, both pages invalid
    task automatic init_table();
        for (int i = 0; i < mmu_pkg::TLB_NUM; i++) begin
            tlb_write(i, {19'h7ff00 + 19'(i), 5'b0, 8'hee}, 32'h0, 32'h0, 12'h000);
        end
    endtask

    task automatic test_write_read();
        // bits 12..8 and 31..26 written as ones, expected back as zero
        tlb_write(3, 32'h0040_3f11, make_lo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b1) | 32'hfc00_0000,
                  make_lo(20'h2468a, 3'd2, 1'b0, 1'b1, 1'b0), 12'h000);
        tlb_write(7, 32'h0080_6022, make_lo(20'h00abf, 3'd5, 1'b1, 1'b1, 1'b1),
                  make_lo(20'h00cd3, 3'd4, 1'b1, 1'b1, 1'b1), 12'h003);
        tlb_read(3);
        tlb_read(7);
    endtask

    task automatic test_probe();
        tlb_probe(32'h0040_2011);
        tlb_probe(32'h0080_0055);
        tlb_probe(32'h0700_0011);
    endtask

    task automatic test_translate();
        int stalls;
        queue_req(32'h0040_2abc, 1'b0);
        queue_req(32'h0040_3abc, 1'b0);
        queue_req(32'h0080_1234, 1'b0);
        queue_req(32'h0080_5678, 1'b0);
        run_stream(1'b1, 1'b0, stalls);
    endtask

    task automatic test_faults();
        int stalls;
        tlb_write(12, 32'h0100_0022, make_lo(20'h0aaaa, 3'd1, 1'b1, 1'b1, 1'b0),
                  make_lo(20'h0bbbb, 3'd1, 1'b1, 1'b1, 1'b0), 12'h000);
        tlb_write(20, 32'h0200_0011, make_lo(20'h0cccc, 3'd2, 1'b1, 1'b0, 1'b0),
                  make_lo(20'h0dddd, 3'd2, 1'b1, 1'b1, 1'b0), 12'h000);
        queue_req(32'h0600_0100, 1'b0);
        queue_req(32'h0600_0200, 1'b1);
        queue_req(32'h0200_0040, 1'b0);
        queue_req(32'h0040_3010, 1'b1);
        queue_req(32'h0100_0800, 1'b0);
        run_stream(1'b1, 1'b0, stalls);
    endtask

    task automatic test_backpressure();
        int stalls;
        logic [31:0] bases [0:4];
        bases = '{32'h0040_2000, 32'h0080_0000, 32'h0100_0000, 32'h0200_0000, 32'h0700_0000};
        rng_state = xorshift32(rng_state);
        tlb_write(12, 32'h0100_0011, make_lo(rng_state[19:0], 3'd6, 1'b1, 1'b1, 1'b0),
                  make_lo(rng_state[31:12], 3'd7, 1'b0, 1'b1, 1'b0), 12'h000);
        for (int n = 0; n < 20; n++) begin
            rng_state = xorshift32(rng_state);
            queue_req(bases[rng_state[31:8] % 5] | (rng_state & 32'h0000_3ffc), rng_state[0]);
        end
        run_stream(1'b0, 1'b1, stalls);
        if (stalls == 0) begin
            value_errors++;
            $display("req_ready_o never fell while responses were held back");
        end
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_va = '0;
        req_store = 1'b0;
        rsp_ready = 1'b1;
        asid = 8'h11;
        maint_valid = 1'b0;
        maint_op = mmu_pkg::OP_READ;
        index = '0;
        entryhi = '0;
        entrylo0 = '0;
        entrylo1 = '0;
        mask = '0;
        value_errors = 0;
        timeouts = 0;
        rng_state = 32'hdd79_dcf1;
        repeat (2) @(posedge clk);
        #0.5;
        rst = 1'b0;
        @(negedge clk);
        check_flag("req_ready_o", 1'b1, req_ready);
        check_flag("rsp_valid_o", 1'b0, rsp_valid);
        next_cycle();
        init_table();
        test_write_read();
        test_probe();
        test_translate();
        test_faults();
        test_backpressure();
        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/mmu_pkg.sv
logic/tlb_entry_array.sv
logic/tlb_lookup.sv
logic/xlat_fault.sv
logic/xlat_pipe_stage.sv
logic/mmu_top.sv
verification/mmu_tb.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - files:
      - logic/mmu_pkg.sv
      - logic/tlb_entry_array.sv
      - logic/tlb_lookup.sv
      - logic/xlat_fault.sv
      - logic/xlat_pipe_stage.sv
      - logic/mmu_top.sv
  - target: test
    files:
      - verification/mmu_tb.sv
